/* logic/streamer_pkg.sv */
package streamer_pkg;

  // Datapath and address widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned LEN_W  = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;

  localparam int unsigned NUM_LOADS = 3;
  // Three loads plus the store
  localparam int unsigned NUM_PORTS = 4;

  // Mux input of each channel
  typedef enum logic [1:0] {
    X_ID = 2'd0,
    W_ID = 2'd1,
    Y_ID = 2'd2,
    Z_ID = 2'd3
  } chan_id_e;

  // Strided job of one channel, stride in bytes
  typedef struct packed {
    logic  start;
    addr_t base;
    addr_t stride;
    len_t  len;
  } chan_ctrl_t;

  typedef struct packed {
    chan_ctrl_t x;
    chan_ctrl_t w;
    chan_ctrl_t y;
    chan_ctrl_t z;
  } streamer_ctrl_t;

  typedef struct packed {
    logic busy;
    logic done;
  } chan_flags_t;

  typedef struct packed {
    chan_flags_t x;
    chan_flags_t w;
    chan_flags_t y;
    chan_flags_t z;
  } streamer_flags_t;

  // Memory port, wen high for a write
  typedef struct packed {
    logic  req;
    logic  wen;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } mem_rsp_t;

  // Forward half of a stream, ready travels on its own
  typedef struct packed {
    logic  valid;
    data_t data;
  } stream_t;

  typedef enum logic {
    SRC_IDLE,
    SRC_RUN
  } src_state_e;

  typedef enum logic {
    SNK_IDLE,
    SNK_RUN
  } snk_state_e;

endpackage

/* logic/sync_fifo.sv */
module sync_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 32
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       push_i,
  input  logic [WIDTH-1:0]           data_i,
  input  logic                       pop_i,
  output logic [WIDTH-1:0]           data_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (32'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (32'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (32'(count_q) == DEPTH);
  assign count_o = count_q;

endmodule

/* logic/addr_gen.sv */
module addr_gen (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                start_i,
  input  streamer_pkg::addr_t base_i,
  input  streamer_pkg::addr_t stride_i,
  input  streamer_pkg::len_t  len_i,
  input  logic                step_i,
  output streamer_pkg::addr_t addr_o,
  output logic                last_o
);

  streamer_pkg::addr_t addr_q;
  streamer_pkg::addr_t stride_q;
  streamer_pkg::len_t  remaining_q;

  // Stride is held so the control bus may change mid-job
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (step_i && (remaining_q != '0)) begin
      addr_q <= addr_q + stride_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      remaining_q <= '0;
    end else if (start_i) begin
      remaining_q <= len_i;
    end else if (step_i && (remaining_q != '0)) begin
      remaining_q <= remaining_q - 1'b1;
    end
  end

  assign addr_o = addr_q;
  // Current item is the final one of the job
  assign last_o = (remaining_q == streamer_pkg::len_t'(1));

endmodule

/* logic/stream_source.sv */
module stream_source #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  streamer_pkg::chan_ctrl_t  ctrl_i,
  output streamer_pkg::chan_flags_t flags_o,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  logic                      gnt_i,
  input  logic                      rvalid_i,
  input  streamer_pkg::data_t       rdata_i,
  output streamer_pkg::stream_t     stream_o,
  input  logic                      ready_i
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  streamer_pkg::src_state_e state_q;
  streamer_pkg::addr_t      addr;
  streamer_pkg::len_t       beats_left_q;
  logic [CNT_W-1:0]         fifo_count;
  logic [CNT_W-1:0]         inflight_q;
  logic                     start;
  logic                     last_addr;
  logic                     issue_done_q;
  logic                     granted;
  logic                     pop;
  logic                     fifo_empty;
  logic                     done_q;

  // A start while running is dropped
  assign start = ctrl_i.start && (state_q == streamer_pkg::SRC_IDLE);

  addr_gen i_addr_gen (
    .clk_i    ( clk_i         ),
    .rst_i    ( rst_i         ),
    .start_i  ( start         ),
    .base_i   ( ctrl_i.base   ),
    .stride_i ( ctrl_i.stride ),
    .len_i    ( ctrl_i.len    ),
    .step_i   ( granted       ),
    .addr_o   ( addr          ),
    .last_o   ( last_addr     )
  );

  // Credits cover buffered beats and reads still in flight
  assign mem_req_o.req   = (state_q == streamer_pkg::SRC_RUN) && !issue_done_q &&
                           ((32'(fifo_count) + 32'(inflight_q)) < DEPTH);
  assign mem_req_o.wen   = 1'b0;
  assign mem_req_o.addr  = addr;
  assign mem_req_o.wdata = '0;

  assign granted = mem_req_o.req && gnt_i;

  sync_fifo #(
    .DEPTH ( DEPTH                ),
    .WIDTH ( streamer_pkg::DATA_W )
  ) i_load_fifo (
    .clk_i   ( clk_i         ),
    .rst_i   ( rst_i         ),
    .push_i  ( rvalid_i      ),
    .data_i  ( rdata_i       ),
    .pop_i   ( pop           ),
    .data_o  ( stream_o.data ),
    .empty_o ( fifo_empty    ),
    .full_o  (               ),
    .count_o ( fifo_count    )
  );

  assign stream_o.valid = !fifo_empty;
  assign pop            = stream_o.valid && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q      <= streamer_pkg::SRC_IDLE;
      issue_done_q <= 1'b0;
      beats_left_q <= '0;
      inflight_q   <= '0;
      done_q       <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (granted && !rvalid_i) begin
        inflight_q <= inflight_q + 1'b1;
      end else if (!granted && rvalid_i) begin
        inflight_q <= inflight_q - 1'b1;
      end
      case (state_q)
        streamer_pkg::SRC_IDLE: begin
          if (start) begin
            state_q      <= streamer_pkg::SRC_RUN;
            issue_done_q <= 1'b0;
            beats_left_q <= ctrl_i.len;
          end
        end
        streamer_pkg::SRC_RUN: begin
          if (granted && last_addr) begin
            issue_done_q <= 1'b1;
          end
          // Job ends on the last beat leaving the stream
          if (pop) begin
            beats_left_q <= beats_left_q - 1'b1;
            if (beats_left_q == streamer_pkg::len_t'(1)) begin
              done_q  <= 1'b1;
              state_q <= streamer_pkg::SRC_IDLE;
            end
          end
        end
        default: state_q <= streamer_pkg::SRC_IDLE;
      endcase
    end
  end

  assign flags_o.busy = (state_q == streamer_pkg::SRC_RUN);
  assign flags_o.done = done_q;

endmodule

/* logic/stream_sink.sv */
module stream_sink #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  streamer_pkg::chan_ctrl_t  ctrl_i,
  output streamer_pkg::chan_flags_t flags_o,
  input  streamer_pkg::stream_t     stream_i,
  output logic                      ready_o,
  output streamer_pkg::mem_req_t    mem_req_o,
  input  logic                      gnt_i
);

  localparam int unsigned ENTRY_W = streamer_pkg::ADDR_W + streamer_pkg::DATA_W;

  streamer_pkg::snk_state_e state_q;
  streamer_pkg::addr_t      addr;
  streamer_pkg::len_t       writes_left_q;
  logic [ENTRY_W-1:0]       head;
  logic                     start;
  logic                     last_addr;
  logic                     accept;
  logic                     accept_done_q;
  logic                     granted;
  logic                     fifo_empty;
  logic                     fifo_full;
  logic                     done_q;

  assign start   = ctrl_i.start && (state_q == streamer_pkg::SNK_IDLE);
  assign ready_o = (state_q == streamer_pkg::SNK_RUN) && !accept_done_q && !fifo_full;
  assign accept  = stream_i.valid && ready_o;

  // Address advances per accepted beat, not per write
  addr_gen i_addr_gen (
    .clk_i    ( clk_i         ),
    .rst_i    ( rst_i         ),
    .start_i  ( start         ),
    .base_i   ( ctrl_i.base   ),
    .stride_i ( ctrl_i.stride ),
    .len_i    ( ctrl_i.len    ),
    .step_i   ( accept        ),
    .addr_o   ( addr          ),
    .last_o   ( last_addr     )
  );

  sync_fifo #(
    .DEPTH ( DEPTH   ),
    .WIDTH ( ENTRY_W )
  ) i_store_fifo (
    .clk_i   ( clk_i                  ),
    .rst_i   ( rst_i                  ),
    .push_i  ( accept                 ),
    .data_i  ( {addr, stream_i.data}  ),
    .pop_i   ( granted                ),
    .data_o  ( head                   ),
    .empty_o ( fifo_empty             ),
    .full_o  ( fifo_full              ),
    .count_o (                        )
  );

  // FIFO head is the pending write
  assign mem_req_o.req   = !fifo_empty;
  assign mem_req_o.wen   = 1'b1;
  assign mem_req_o.addr  = head[ENTRY_W-1:streamer_pkg::DATA_W];
  assign mem_req_o.wdata = head[streamer_pkg::DATA_W-1:0];

  assign granted = mem_req_o.req && gnt_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= streamer_pkg::SNK_IDLE;
      accept_done_q <= 1'b0;
      writes_left_q <= '0;
      done_q        <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        streamer_pkg::SNK_IDLE: begin
          if (start) begin
            state_q       <= streamer_pkg::SNK_RUN;
            accept_done_q <= 1'b0;
            writes_left_q <= ctrl_i.len;
          end
        end
        streamer_pkg::SNK_RUN: begin
          if (accept && last_addr) begin
            accept_done_q <= 1'b1;
          end
          // Completion follows the grant of the final write
          if (granted) begin
            writes_left_q <= writes_left_q - 1'b1;
            if (writes_left_q == streamer_pkg::len_t'(1)) begin
              done_q  <= 1'b1;
              state_q <= streamer_pkg::SNK_IDLE;
            end
          end
        end
        default: state_q <= streamer_pkg::SNK_IDLE;
      endcase
    end
  end

  assign flags_o.busy = (state_q == streamer_pkg::SNK_RUN);
  assign flags_o.done = done_q;

endmodule

/* logic/mem_port_mux.sv */
module mem_port_mux (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  streamer_pkg::mem_req_t [streamer_pkg::NUM_PORTS-1:0] chan_req_i,
  output logic [streamer_pkg::NUM_PORTS-1:0]            chan_gnt_o,
  output logic [streamer_pkg::NUM_LOADS-1:0]            load_rvalid_o,
  output streamer_pkg::data_t                           rdata_o,
  output streamer_pkg::mem_req_t                        mem_req_o,
  input  streamer_pkg::mem_rsp_t                        mem_rsp_i
);

  localparam int unsigned PORT_W = $clog2(streamer_pkg::NUM_PORTS);

  logic [PORT_W-1:0]      rr_q;
  logic [PORT_W-1:0]      winner;
  logic                   found;
  logic                   granted;
  streamer_pkg::chan_id_e rd_id_q;

  // First requester at or after the round-robin pointer
  always_comb begin
    logic [PORT_W-1:0] cand;
    found  = 1'b0;
    winner = rr_q;
    cand   = rr_q;
    for (int k = 0; k < streamer_pkg::NUM_PORTS; k++) begin
      cand = PORT_W'((int'(rr_q) + k) % streamer_pkg::NUM_PORTS);
      if (!found && chan_req_i[cand].req) begin
        found  = 1'b1;
        winner = cand;
      end
    end
  end

  always_comb begin
    mem_req_o = '0;
    if (found) begin
      mem_req_o = chan_req_i[winner];
    end
  end

  // Grant goes back only to the winner
  always_comb begin
    chan_gnt_o = '0;
    chan_gnt_o[winner] = found & mem_rsp_i.gnt;
  end

  assign granted = found & mem_rsp_i.gnt;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q    <= '0;
      rd_id_q <= streamer_pkg::X_ID;
    end else if (granted) begin
      rr_q <= PORT_W'((int'(winner) + 1) % streamer_pkg::NUM_PORTS);
      // Remember who owns the response of the next cycle
      if (!chan_req_i[winner].wen) begin
        rd_id_q <= streamer_pkg::chan_id_e'(winner);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < streamer_pkg::NUM_LOADS; i++) begin
      load_rvalid_o[i] = mem_rsp_i.r_valid && (int'(rd_id_q) == i);
    end
  end

  // Data is shared, r_valid picks the owner
  assign rdata_o = mem_rsp_i.r_data;

endmodule

/* logic/streamer_top.sv */
module streamer_top #(
  parameter int unsigned LOAD_FIFO_DEPTH  = 4,
  parameter int unsigned STORE_FIFO_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  streamer_pkg::streamer_ctrl_t  ctrl_i,
  output streamer_pkg::streamer_flags_t flags_o,
  output streamer_pkg::stream_t         x_stream_o,
  output streamer_pkg::stream_t         w_stream_o,
  output streamer_pkg::stream_t         y_stream_o,
  input  logic                          x_ready_i,
  input  logic                          w_ready_i,
  input  logic                          y_ready_i,
  input  streamer_pkg::stream_t         z_stream_i,
  output logic                          z_ready_o,
  output streamer_pkg::mem_req_t        mem_req_o,
  input  streamer_pkg::mem_rsp_t        mem_rsp_i
);

  // Channel side of the memory mux, indexed by chan_id_e
  streamer_pkg::mem_req_t [streamer_pkg::NUM_PORTS-1:0] chan_req;
  logic [streamer_pkg::NUM_PORTS-1:0]                    chan_gnt;
  logic [streamer_pkg::NUM_LOADS-1:0]                    load_rvalid;
  streamer_pkg::data_t                                   rdata;

  stream_source #(
    .DEPTH ( LOAD_FIFO_DEPTH )
  ) i_x_source (
    .clk_i     ( clk_i                           ),
    .rst_i     ( rst_i                           ),
    .ctrl_i    ( ctrl_i.x                        ),
    .flags_o   ( flags_o.x                       ),
    .mem_req_o ( chan_req[streamer_pkg::X_ID]    ),
    .gnt_i     ( chan_gnt[streamer_pkg::X_ID]    ),
    .rvalid_i  ( load_rvalid[streamer_pkg::X_ID] ),
    .rdata_i   ( rdata                           ),
    .stream_o  ( x_stream_o                      ),
    .ready_i   ( x_ready_i                       )
  );

  stream_source #(
    .DEPTH ( LOAD_FIFO_DEPTH )
  ) i_w_source (
    .clk_i     ( clk_i                           ),
    .rst_i     ( rst_i                           ),
    .ctrl_i    ( ctrl_i.w                        ),
    .flags_o   ( flags_o.w                       ),
    .mem_req_o ( chan_req[streamer_pkg::W_ID]    ),
    .gnt_i     ( chan_gnt[streamer_pkg::W_ID]    ),
    .rvalid_i  ( load_rvalid[streamer_pkg::W_ID] ),
    .rdata_i   ( rdata                           ),
    .stream_o  ( w_stream_o                      ),
    .ready_i   ( w_ready_i                       )
  );

  stream_source #(
    .DEPTH ( LOAD_FIFO_DEPTH )
  ) i_y_source (
    .clk_i     ( clk_i                           ),
    .rst_i     ( rst_i                           ),
    .ctrl_i    ( ctrl_i.y                        ),
    .flags_o   ( flags_o.y                       ),
    .mem_req_o ( chan_req[streamer_pkg::Y_ID]    ),
    .gnt_i     ( chan_gnt[streamer_pkg::Y_ID]    ),
    .rvalid_i  ( load_rvalid[streamer_pkg::Y_ID] ),
    .rdata_i   ( rdata                           ),
    .stream_o  ( y_stream_o                      ),
    .ready_i   ( y_ready_i                       )
  );

  // Store channel takes the last mux input
  stream_sink #(
    .DEPTH ( STORE_FIFO_DEPTH )
  ) i_z_sink (
    .clk_i     ( clk_i                        ),
    .rst_i     ( rst_i                        ),
    .ctrl_i    ( ctrl_i.z                     ),
    .flags_o   ( flags_o.z                    ),
    .stream_i  ( z_stream_i                   ),
    .ready_o   ( z_ready_o                    ),
    .mem_req_o ( chan_req[streamer_pkg::Z_ID] ),
    .gnt_i     ( chan_gnt[streamer_pkg::Z_ID] )
  );

  mem_port_mux i_mem_port_mux (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .chan_req_i    ( chan_req    ),
    .chan_gnt_o    ( chan_gnt    ),
    .load_rvalid_o ( load_rvalid ),
    .rdata_o       ( rdata       ),
    .mem_req_o     ( mem_req_o   ),
    .mem_rsp_i     ( mem_rsp_i   )
  );

endmodule

/* sim/tcdm_model.sv */
module tcdm_model #(
  parameter int unsigned WORDS = 1024
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  streamer_pkg::mem_req_t req_i,
  output streamer_pkg::mem_rsp_t rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned IDX_W = $clog2(WORDS);

  streamer_pkg::data_t mem_q [WORDS];
  logic [IDX_W-1:0]    word_idx;
  logic                gnt_q;
  logic                rvalid_q;
  streamer_pkg::data_t rdata_q;
  int                  seed;

  // Untouched words read back as their byte address with a fixed mask
  initial begin
    seed = 32'hde71;
    for (int i = 0; i < WORDS; i++) begin
      mem_q[i] = streamer_pkg::data_t'(i * 4) ^ 32'hA5A5_0000;
    end
  end

  assign word_idx = req_i.addr[IDX_W+1:2];

  always @(posedge clk_i) begin
    if (rst_i) begin
      gnt_q    <= 1'b0;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      // Grant stalls in about one cycle out of four
      gnt_q    <= (($random(seed) & 3) != 0);
      rvalid_q <= req_i.req && gnt_q && !req_i.wen;
      if (req_i.req && gnt_q) begin
        if (req_i.wen) begin
          mem_q[word_idx] <= req_i.wdata;
        end else begin
          rdata_q <= mem_q[word_idx];
        end
      end
    end
  end

  assign rsp_o.gnt     = gnt_q;
  assign rsp_o.r_valid = rvalid_q;
  assign rsp_o.r_data  = rdata_q;

endmodule

/* sim/streamer_tb.sv */
module streamer_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned TIMEOUT_CYCLES = 4000;

  logic                          clk = 1'b0;
  logic                          rst;
  streamer_pkg::streamer_ctrl_t  ctrl;
  streamer_pkg::streamer_flags_t flags;
  streamer_pkg::stream_t [2:0]   load_stream;
  logic [2:0]                    load_ready = '0;
  streamer_pkg::stream_t         z_stream;
  logic                          z_ready;
  streamer_pkg::mem_req_t        mem_req;
  streamer_pkg::mem_rsp_t        mem_rsp;

  logic [3:0]          busy;
  logic [3:0]          done;
  logic [3:0]          busy_prev;
  logic [2:0]          hold_q;
  streamer_pkg::data_t hold_data [3];
  streamer_pkg::addr_t base_q [4];
  streamer_pkg::addr_t stride_q [4];
  streamer_pkg::len_t  len_q [4];
  int                  beat_cnt [4];
  int                  done_cnt [4];
  int                  wait_cnt [4];
  streamer_pkg::data_t written [streamer_pkg::addr_t];
  streamer_pkg::addr_t wr_addr_q [$];
  streamer_pkg::data_t wr_data_q [$];
  streamer_pkg::addr_t exp_addr;
  streamer_pkg::data_t exp_data;
  int                  ready_seed = 32'hde71;
  int unsigned         cycles = 0;
  string               load_name [3] = '{"x_stream_o", "w_stream_o", "y_stream_o"};

  always #10 clk = ~clk;

  always @(posedge clk) begin
    load_ready <= 3'($random(ready_seed));
  end

  streamer_top #(
    .LOAD_FIFO_DEPTH  ( 4 ),
    .STORE_FIFO_DEPTH ( 2 )
  ) i_streamer_top (
    .clk_i      ( clk            ),
    .rst_i      ( rst            ),
    .ctrl_i     ( ctrl           ),
    .flags_o    ( flags          ),
    .x_stream_o ( load_stream[0] ),
    .w_stream_o ( load_stream[1] ),
    .y_stream_o ( load_stream[2] ),
    .x_ready_i  ( load_ready[0]  ),
    .w_ready_i  ( load_ready[1]  ),
    .y_ready_i  ( load_ready[2]  ),
    .z_stream_i ( z_stream       ),
    .z_ready_o  ( z_ready        ),
    .mem_req_o  ( mem_req        ),
    .mem_rsp_i  ( mem_rsp        )
  );

  tcdm_model i_tcdm_model (
    .clk_i ( clk     ),
    .rst_i ( rst     ),
    .req_i ( mem_req ),
    .rsp_o ( mem_rsp )
  );

  assign busy = {flags.z.busy, flags.y.busy, flags.w.busy, flags.x.busy};
  assign done = {flags.z.done, flags.y.done, flags.w.done, flags.x.done};

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1, "Stopped at the first failure");
  endtask

  // Memory content as seen by the testbench
  function automatic streamer_pkg::data_t expected_word(input streamer_pkg::addr_t a);
    if (written.exists(a)) begin
      return written[a];
    end else begin
      return a ^ 32'hA5A5_0000;
    end
  endfunction

  task automatic set_ctrl(input int ch, input streamer_pkg::chan_ctrl_t job);
    case (ch)
      0: ctrl.x <= job;
      1: ctrl.w <= job;
      2: ctrl.y <= job;
      default: ctrl.z <= job;
    endcase
  endtask

  task automatic start_job(input int ch, input streamer_pkg::addr_t base,
                           input streamer_pkg::addr_t stride, input streamer_pkg::len_t len);
    streamer_pkg::chan_ctrl_t job;
    job = '{start: 1'b1, base: base, stride: stride, len: len};
    base_q[ch]   = base;
    stride_q[ch] = stride;
    len_q[ch]    = len;
    @(posedge clk);
    set_ctrl(ch, job);
    @(posedge clk);
    job.start = 1'b0;
    set_ctrl(ch, job);
    @(negedge clk);
    assert (busy[ch]) else report_mismatch($sformatf("flags_o[%0d].busy", ch), 1, 0);
  endtask

  // Start pulse with a different job while the channel is running
  task automatic restart_busy(input int ch);
    streamer_pkg::chan_ctrl_t job;
    job = '{start: 1'b1, base: 32'h3F0, stride: 32'd16, len: 16'd2};
    @(posedge clk);
    set_ctrl(ch, job);
    @(posedge clk);
    job.start = 1'b0;
    set_ctrl(ch, job);
  endtask

  task automatic send_z(input int n, input streamer_pkg::data_t first);
    int k;
    k = 0;
    @(posedge clk);
    z_stream <= '{valid: 1'b1, data: first};
    while (k < n) begin
      @(negedge clk);
      if (z_ready) begin
        k++;
        @(posedge clk);
        if (k < n) begin
          z_stream <= '{valid: 1'b1, data: first + streamer_pkg::data_t'(k) * 32'h0101_0003};
        end else begin
          z_stream <= '0;
        end
      end
    end
  endtask

  task automatic wait_done(input int ch, input int n);
    while (done_cnt[ch] < n) begin
      @(posedge clk);
    end
  endtask

  task automatic check_idle();
    @(negedge clk);
    assert (flags == '0) else report_mismatch("flags_o", 0, 32'(flags));
    assert (z_ready == 1'b0) else report_mismatch("z_ready_o", 0, 32'(z_ready));
    assert (mem_req.req == 1'b0) else report_mismatch("mem_req_o.req", 0, 32'(mem_req.req));
    for (int i = 0; i < 3; i++) begin
      assert (!load_stream[i].valid)
        else report_mismatch({load_name[i], ".valid"}, 0, 1);
    end
  endtask

  always @(negedge clk) begin
    if (rst) begin
      busy_prev = '0;
      hold_q    = '0;
      for (int i = 0; i < 4; i++) begin
        beat_cnt[i] = 0;
        done_cnt[i] = 0;
        wait_cnt[i] = 0;
      end
    end else begin
      // Done pulses once per job in the first cycle without busy
      for (int i = 0; i < 4; i++) begin
        assert (done[i] == (busy_prev[i] && !busy[i]))
          else report_mismatch($sformatf("flags_o[%0d].done", i),
                               32'(busy_prev[i] && !busy[i]), 32'(done[i]));
        if (done[i]) begin
          assert (beat_cnt[i] == int'(len_q[i]))
            else report_mismatch($sformatf("beat count of channel %0d", i),
                                 32'(len_q[i]), 32'(beat_cnt[i]));
          beat_cnt[i] = 0;
          done_cnt[i]++;
        end
      end
      assert (!done[3] || wr_addr_q.size() == 0)
        else report_error("store job finished with writes still pending");
      for (int i = 0; i < 3; i++) begin
        if (hold_q[i]) begin
          assert (load_stream[i].valid)
            else report_mismatch({load_name[i], ".valid"}, 1, 0);
          assert (load_stream[i].data == hold_data[i])
            else report_mismatch({load_name[i], ".data"}, hold_data[i], load_stream[i].data);
        end
        if (load_stream[i].valid && load_ready[i]) begin
          assert (beat_cnt[i] < int'(len_q[i]))
            else report_error($sformatf("%s delivered more beats than the job length",
                                        load_name[i]));
          exp_addr = base_q[i] + streamer_pkg::addr_t'(beat_cnt[i]) * stride_q[i];
          exp_data = expected_word(exp_addr);
          assert (load_stream[i].data == exp_data)
            else report_mismatch({load_name[i], ".data"}, exp_data, load_stream[i].data);
          beat_cnt[i]++;
        end
        hold_q[i]    = load_stream[i].valid && !load_ready[i];
        hold_data[i] = load_stream[i].data;
      end
      // Accepted Z beats turn into expected writes
      if (z_stream.valid && z_ready) begin
        exp_addr = base_q[3] + streamer_pkg::addr_t'(beat_cnt[3]) * stride_q[3];
        wr_addr_q.push_back(exp_addr);
        wr_data_q.push_back(z_stream.data);
        written[exp_addr] = z_stream.data;
        beat_cnt[3]++;
      end
      if (mem_req.req && mem_rsp.gnt && mem_req.wen) begin
        if (wr_addr_q.size() == 0) begin
          report_error("memory write granted without an accepted Z beat");
        end else begin
          assert (mem_req.addr == wr_addr_q[0])
            else report_mismatch("mem_req_o.addr", wr_addr_q[0], mem_req.addr);
          assert (mem_req.wdata == wr_data_q[0])
            else report_mismatch("mem_req_o.wdata", wr_data_q[0], mem_req.wdata);
          void'(wr_addr_q.pop_front());
          void'(wr_data_q.pop_front());
        end
      end
      // Round-robin arbitration grants one channel per port transfer
      assert ($countones(i_streamer_top.chan_gnt) == int'(mem_req.req && mem_rsp.gnt))
        else report_mismatch("number of channel grants",
                             32'(mem_req.req && mem_rsp.gnt),
                             32'($countones(i_streamer_top.chan_gnt)));
      if (|i_streamer_top.chan_gnt) begin
        for (int i = 0; i < 4; i++) begin
          if (i_streamer_top.chan_gnt[i]) begin
            assert (i_streamer_top.chan_req[i] == mem_req)
              else report_error($sformatf("channel %0d granted for a request of another",
                                          i));
            wait_cnt[i] = 0;
          end else if (i_streamer_top.chan_req[i].req) begin
            wait_cnt[i]++;
            assert (wait_cnt[i] <= 3)
              else report_error($sformatf("channel %0d passed over more than 3 times", i));
          end else begin
            wait_cnt[i] = 0;
          end
        end
      end
      busy_prev = busy;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      report_error("run did not finish within the cycle limit");
    end
  end

  initial begin
    rst      = 1'b1;
    ctrl     = '0;
    z_stream = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    check_idle();

    // Single loads where X gets a second start while busy
    start_job(streamer_pkg::X_ID, 32'h100, 32'd4, 16'd8);
    restart_busy(streamer_pkg::X_ID);
    wait_done(streamer_pkg::X_ID, 1);
    start_job(streamer_pkg::W_ID, 32'h200, 32'd12, 16'd6);
    start_job(streamer_pkg::Y_ID, 32'h040, 32'd4, 16'd5);
    wait_done(streamer_pkg::W_ID, 1);
    wait_done(streamer_pkg::Y_ID, 1);

    // Store and then read the region back
    start_job(streamer_pkg::Z_ID, 32'h800, 32'd8, 16'd8);
    send_z(8, 32'h3C00_0000);
    wait_done(streamer_pkg::Z_ID, 1);
    start_job(streamer_pkg::Y_ID, 32'h800, 32'd8, 16'd8);
    wait_done(streamer_pkg::Y_ID, 2);

    // All four channels compete for the port
    start_job(streamer_pkg::X_ID, 32'h000, 32'd4, 16'd8);
    start_job(streamer_pkg::W_ID, 32'h180, 32'd12, 16'd6);
    start_job(streamer_pkg::Y_ID, 32'h300, 32'd4, 16'd5);
    start_job(streamer_pkg::Z_ID, 32'h900, 32'd4, 16'd8);
    send_z(8, 32'h7E00_0000);
    wait_done(streamer_pkg::X_ID, 2);
    wait_done(streamer_pkg::W_ID, 2);
    wait_done(streamer_pkg::Y_ID, 3);
    wait_done(streamer_pkg::Z_ID, 2);
    @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

/* matrix_streamer.f */
logic/streamer_pkg.sv
logic/sync_fifo.sv
logic/addr_gen.sv
logic/stream_source.sv
logic/stream_sink.sv
logic/mem_port_mux.sv
logic/streamer_top.sv
sim/tcdm_model.sv
sim/streamer_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module streamer_tb -f matrix_streamer.f -o streamer_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/streamer_sim > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
